//--- common/rp_defs.svh
`ifndef RP_DEFS_SVH
`define RP_DEFS_SVH

//////////////////////////////////////////////////
// Signal path widths
//////////////////////////////////////////////////

`define RP_ADC_RAW_W 16          // Raw ADC word incl. reserved LSBs
`define RP_SMP_W     14          // Signed sample
`define RP_N_CH      2           // Analog channels

//////////////////////////////////////////////////
// System bus layout
//////////////////////////////////////////////////

`define RP_SYS_AW    32
`define RP_SYS_DW    32
`define RP_REG_AW    20          // Offset inside one region
`define RP_N_REG     8           // Regions on address bits 22..20

`define RP_HK_ID     32'h5250_0001  // Housekeeping ID word

`endif

//--- common/rp_pkg.sv
`include "rp_defs.svh"

package rp_pkg;

  // Signed sample and one-per-channel bundle
  typedef logic signed [`RP_SMP_W-1:0] sample_t;
  typedef sample_t [`RP_N_CH-1:0]      sample_arr_t;

  // System bus words
  typedef logic [`RP_SYS_AW-1:0] sys_addr_t;
  typedef logic [`RP_SYS_DW-1:0] sys_data_t;

  // Negative-slope offset code <-> two's complement
  // Same rule both ways, keep MSB and invert the rest
  function automatic logic [`RP_SMP_W-1:0] code_flip(input logic [`RP_SMP_W-1:0] val);
    return {val[`RP_SMP_W-1], ~val[`RP_SMP_W-2:0]};
  endfunction

  // Signed sample to bus word
  function automatic sys_data_t smp_sext(input sample_t smp);
    return sys_data_t'(smp);  // Sign carried by the signed argument
  endfunction

endpackage

//--- rtl/sys_bus_decoder.sv
`include "rp_defs.svh"

module sys_bus_decoder import rp_pkg::*; #(
  parameter logic [`RP_N_REG-1:0] REG_MAP = 'b111  // Regions with a slave behind them
) (
  input  logic                                 adc_clk,
  input  logic                                 reset_i,
  // Master side
  input  sys_addr_t                            sys_addr_i,
  input  sys_data_t                            sys_wdata_i,
  input  logic                                 sys_wen_i,
  input  logic                                 sys_ren_i,
  output sys_data_t                            sys_rdata_o,
  output logic                                 sys_ack_o,
  output logic                                 sys_err_o,
  // Region side
  output logic [`RP_N_REG-1:0][`RP_REG_AW-1:0] reg_addr_o,
  output sys_data_t [`RP_N_REG-1:0]            reg_wdata_o,
  output logic [`RP_N_REG-1:0]                 reg_wen_o,
  output logic [`RP_N_REG-1:0]                 reg_ren_o,
  input  sys_data_t [`RP_N_REG-1:0]            reg_rdata_i,
  input  logic [`RP_N_REG-1:0]                 reg_ack_i
);

  localparam int SEL_W = $clog2(`RP_N_REG);

  logic [SEL_W-1:0]     sel;     // Region of the current strobe
  logic [`RP_N_REG-1:0] sel_oh;
  logic                 strobe;
  logic [SEL_W-1:0]     sel_q;   // Region awaiting its reply
  logic                 miss_q;  // Strobe went to an empty region

  assign sel    = sys_addr_i[`RP_REG_AW +: SEL_W];
  assign sel_oh = `RP_N_REG'(1) << sel;
  assign strobe = sys_wen_i | sys_ren_i;

  //////////////////////////////////////////////////
  // Request steering
  //////////////////////////////////////////////////

  // Only the selected region sees offset, data and strobe
  always_comb begin
    for (int r = 0; r < `RP_N_REG; r++) begin
      reg_addr_o[r]  = sel_oh[r] ? sys_addr_i[`RP_REG_AW-1:0] : '0;
      reg_wdata_o[r] = sel_oh[r] ? sys_wdata_i : '0;
      reg_wen_o[r]   = sel_oh[r] & sys_wen_i;
      reg_ren_o[r]   = sel_oh[r] & sys_ren_i;
    end
  end

  //////////////////////////////////////////////////
  // Reply select
  //////////////////////////////////////////////////

  always_ff @(posedge adc_clk) begin
    if (reset_i) begin
      sel_q  <= '0;
      miss_q <= 1'b0;
    end else begin
      miss_q <= strobe & ~REG_MAP[sel];  // Own error ack next cycle
      if (strobe) begin
        sel_q <= sel;
      end
    end
  end

  assign sys_ack_o   = miss_q | (REG_MAP[sel_q] & reg_ack_i[sel_q]);
  assign sys_err_o   = miss_q;
  assign sys_rdata_o = miss_q ? '0 : reg_rdata_i[sel_q];  // Empty region reads 0

endmodule

//--- rtl/housekeeping.sv
`include "rp_defs.svh"

module housekeeping import rp_pkg::*; (
  input  logic                  adc_clk,
  input  logic                  reset_i,
  // Region bus
  input  logic [`RP_REG_AW-1:0] sys_addr_i,
  input  sys_data_t             sys_wdata_i,
  input  logic                  sys_wen_i,
  input  logic                  sys_ren_i,
  output sys_data_t             sys_rdata_o,
  output logic                  sys_ack_o,
  // Board controls
  output logic                  digital_loop_o,
  output logic [7:0]            led_o
);

  // Register offsets
  localparam logic [`RP_REG_AW-1:0] OFS_ID   = 'h0;
  localparam logic [`RP_REG_AW-1:0] OFS_LOOP = 'h4;
  localparam logic [`RP_REG_AW-1:0] OFS_LED  = 'h8;

  //////////////////////////////////////////////////
  // Control registers
  //////////////////////////////////////////////////

  always_ff @(posedge adc_clk) begin
    if (reset_i) begin
      digital_loop_o <= 1'b0;  // Loopback off
      led_o          <= '0;
      sys_ack_o      <= 1'b0;
    end else begin
      sys_ack_o <= sys_wen_i | sys_ren_i;  // One cycle after strobe
      if (sys_wen_i) begin
        case (sys_addr_i)
          OFS_LOOP: digital_loop_o <= sys_wdata_i[0];
          OFS_LED:  led_o          <= sys_wdata_i[7:0];
          default:  ;                       // ID and holes ignore writes
        endcase
      end
    end
  end

  // Read data
  always_ff @(posedge adc_clk) begin
    if (sys_ren_i) begin
      case (sys_addr_i)
        OFS_ID:   sys_rdata_o <= `RP_HK_ID;
        OFS_LOOP: sys_rdata_o <= sys_data_t'(digital_loop_o);
        OFS_LED:  sys_rdata_o <= sys_data_t'(led_o);
        default:  sys_rdata_o <= '0;
      endcase
    end
  end

endmodule

//--- rtl/dc_gen.sv
`include "rp_defs.svh"

module dc_gen import rp_pkg::*; (
  input  logic                  adc_clk,
  input  logic                  reset_i,
  // Region bus
  input  logic [`RP_REG_AW-1:0] sys_addr_i,
  input  sys_data_t             sys_wdata_i,
  input  logic                  sys_wen_i,
  input  logic                  sys_ren_i,
  output sys_data_t             sys_rdata_o,
  output logic                  sys_ack_o,
  // Generator output
  output sample_arr_t           level_o
);

  localparam int CH_STRIDE = 'h4;  // One word per channel

  //////////////////////////////////////////////////
  // Level registers
  //////////////////////////////////////////////////

  // Level reg is the output, new value visible with the ack
  always_ff @(posedge adc_clk) begin
    if (reset_i) begin
      level_o   <= '0;
      sys_ack_o <= 1'b0;
    end else begin
      sys_ack_o <= sys_wen_i | sys_ren_i;
      if (sys_wen_i) begin
        for (int c = 0; c < `RP_N_CH; c++) begin
          if (sys_addr_i == `RP_REG_AW'(c * CH_STRIDE)) begin
            level_o[c] <= sys_wdata_i[`RP_SMP_W-1:0];
          end
        end
      end
    end
  end

  // Readback, sign extended
  always_ff @(posedge adc_clk) begin
    if (sys_ren_i) begin
      sys_rdata_o <= '0;  // Unknown offset
      for (int c = 0; c < `RP_N_CH; c++) begin
        if (sys_addr_i == `RP_REG_AW'(c * CH_STRIDE)) begin
          sys_rdata_o <= smp_sext(level_o[c]);
        end
      end
    end
  end

endmodule

//--- rtl/prop_ctrl.sv
`include "rp_defs.svh"

module prop_ctrl import rp_pkg::*; (
  input  logic                  adc_clk,
  input  logic                  reset_i,
  // Region bus
  input  logic [`RP_REG_AW-1:0] sys_addr_i,
  input  sys_data_t             sys_wdata_i,
  input  logic                  sys_wen_i,
  input  logic                  sys_ren_i,
  output sys_data_t             sys_rdata_o,
  output logic                  sys_ack_o,
  // Samples
  input  sample_arr_t           smp_i,
  output sample_arr_t           ctrl_o
);

  localparam int SW = `RP_SMP_W;
  localparam int EW = SW + 1;   // Error, setpoint minus input
  localparam int PW = EW + SW;  // Error times gain

  localparam logic signed [PW-1:0] SAT_MAX = (2 ** (SW - 1)) - 1;
  localparam logic signed [PW-1:0] SAT_MIN = -(2 ** (SW - 1));

  // Per-channel map
  localparam int CH_STRIDE = 'h10;
  localparam int OFS_SET   = 'h0;
  localparam int OFS_GAIN  = 'h4;
  localparam int OFS_SHIFT = 'h8;

  sample_t              set_q   [`RP_N_CH];
  sample_t              gain_q  [`RP_N_CH];
  logic [3:0]           shift_q [`RP_N_CH];
  logic signed [EW-1:0] err_q   [`RP_N_CH];  // Stage 1
  logic signed [PW-1:0] prod    [`RP_N_CH];
  logic signed [PW-1:0] shf     [`RP_N_CH];
  sample_t              sat     [`RP_N_CH];

  //////////////////////////////////////////////////
  // Configuration registers
  //////////////////////////////////////////////////

  always_ff @(posedge adc_clk) begin
    if (reset_i) begin
      for (int c = 0; c < `RP_N_CH; c++) begin
        set_q[c]   <= '0;
        gain_q[c]  <= '0;  // Zero gain, output stays 0
        shift_q[c] <= '0;
      end
      sys_ack_o <= 1'b0;
    end else begin
      sys_ack_o <= sys_wen_i | sys_ren_i;
      if (sys_wen_i) begin
        for (int c = 0; c < `RP_N_CH; c++) begin
          if (sys_addr_i == `RP_REG_AW'(c * CH_STRIDE + OFS_SET))
            set_q[c] <= sys_wdata_i[SW-1:0];
          if (sys_addr_i == `RP_REG_AW'(c * CH_STRIDE + OFS_GAIN))
            gain_q[c] <= sys_wdata_i[SW-1:0];
          if (sys_addr_i == `RP_REG_AW'(c * CH_STRIDE + OFS_SHIFT))
            shift_q[c] <= sys_wdata_i[3:0];
        end
      end
    end
  end

  always_ff @(posedge adc_clk) begin
    if (sys_ren_i) begin
      sys_rdata_o <= '0;
      for (int c = 0; c < `RP_N_CH; c++) begin
        if (sys_addr_i == `RP_REG_AW'(c * CH_STRIDE + OFS_SET))
          sys_rdata_o <= smp_sext(set_q[c]);
        if (sys_addr_i == `RP_REG_AW'(c * CH_STRIDE + OFS_GAIN))
          sys_rdata_o <= smp_sext(gain_q[c]);
        if (sys_addr_i == `RP_REG_AW'(c * CH_STRIDE + OFS_SHIFT))
          sys_rdata_o <= sys_data_t'(shift_q[c]);  // Unsigned field
      end
    end
  end

  //////////////////////////////////////////////////
  // Two stage datapath
  //////////////////////////////////////////////////

  // Multiply, arithmetic shift, clamp to sample range
  always_comb begin
    for (int c = 0; c < `RP_N_CH; c++) begin
      prod[c] = err_q[c] * gain_q[c];
      shf[c]  = prod[c] >>> shift_q[c];
      sat[c]  = shf[c][SW-1:0];
      if (shf[c] > SAT_MAX)
        sat[c] = SAT_MAX[SW-1:0];
      else if (shf[c] < SAT_MIN)
        sat[c] = SAT_MIN[SW-1:0];
    end
  end

  always_ff @(posedge adc_clk) begin
    if (reset_i) begin
      for (int c = 0; c < `RP_N_CH; c++) begin
        err_q[c] <= '0;
      end
      ctrl_o <= '0;
    end else begin
      for (int c = 0; c < `RP_N_CH; c++) begin
        err_q[c]  <= set_q[c] - $signed(smp_i[c]);  // Full width, no wrap
        ctrl_o[c] <= sat[c];                        // Stage 2
      end
    end
  end

endmodule

//--- analog/adc_frontend.sv
`include "rp_defs.svh"

module adc_frontend import rp_pkg::*; (
  input  logic                                    adc_clk,
  input  logic                                    reset_i,
  input  logic [`RP_N_CH-1:0][`RP_ADC_RAW_W-1:0]  adc_dat_i,      // ADC pins
  input  sample_arr_t                             loop_smp_i,     // Registered DAC samples
  input  logic                                    digital_loop_i,
  output sample_arr_t                             smp_o
);

  // Top 14 bits of each raw word
  logic [`RP_N_CH-1:0][`RP_SMP_W-1:0] raw_q;

  //////////////////////////////////////////////////
  // Input register
  //////////////////////////////////////////////////

  // Two reserved LSBs dropped here
  always_ff @(posedge adc_clk) begin
    if (reset_i) begin
      for (int c = 0; c < `RP_N_CH; c++) begin
        raw_q[c] <= code_flip('0);  // Pin code of a zero sample
      end
    end else begin
      for (int c = 0; c < `RP_N_CH; c++) begin
        raw_q[c] <= adc_dat_i[c][`RP_ADC_RAW_W-1 -: `RP_SMP_W];
      end
    end
  end

  //////////////////////////////////////////////////
  // Conversion and loopback
  //////////////////////////////////////////////////

  always_comb begin
    for (int c = 0; c < `RP_N_CH; c++) begin
      if (digital_loop_i)
        smp_o[c] = loop_smp_i[c];       // Board drives itself
      else
        smp_o[c] = code_flip(raw_q[c]); // Neg slope to two's compl
    end
  end

endmodule

//--- analog/dac_backend.sv
`include "rp_defs.svh"

module dac_backend import rp_pkg::*; (
  input  logic                               adc_clk,
  input  logic                               reset_i,
  input  sample_arr_t                        gen_i,     // Generator level
  input  sample_arr_t                        ctrl_i,    // Controller output
  output sample_arr_t                        smp_o,     // Registered signed sum
  output logic [`RP_N_CH-1:0][`RP_SMP_W-1:0] dac_dat_o  // Pin code
);

  localparam int SW = `RP_SMP_W;

  logic signed [SW:0] sum [`RP_N_CH];  // One guard bit
  sample_t            sat [`RP_N_CH];

  //////////////////////////////////////////////////
  // Sum and saturation
  //////////////////////////////////////////////////

  always_comb begin
    for (int c = 0; c < `RP_N_CH; c++) begin
      sum[c] = $signed(gen_i[c]) + $signed(ctrl_i[c]);
      // Top two bits differ on overflow
      if (sum[c][SW] != sum[c][SW-1])
        sat[c] = {sum[c][SW], {(SW - 1){~sum[c][SW]}}};
      else
        sat[c] = sum[c][SW-1:0];
    end
  end

  // Output register
  always_ff @(posedge adc_clk) begin
    if (reset_i) begin
      smp_o <= '0;  // Pins read 0x1FFF
    end else begin
      for (int c = 0; c < `RP_N_CH; c++) begin
        smp_o[c] <= sat[c];
      end
    end
  end

  // Back to negative-slope code for the converter
  always_comb begin
    for (int c = 0; c < `RP_N_CH; c++) begin
      dac_dat_o[c] = code_flip(smp_o[c]);
    end
  end

endmodule

//--- rtl/rp_top.sv
`include "rp_defs.svh"

module rp_top import rp_pkg::*; (
  input  logic                                   adc_clk,
  input  logic                                   reset_i,
  // Converters
  input  logic [`RP_N_CH-1:0][`RP_ADC_RAW_W-1:0] adc_dat_i,
  output logic [`RP_N_CH-1:0][`RP_SMP_W-1:0]     dac_dat_o,
  output logic [7:0]                             led_o,
  // System bus
  input  sys_addr_t                              sys_addr_i,
  input  sys_data_t                              sys_wdata_i,
  input  logic                                   sys_wen_i,
  input  logic                                   sys_ren_i,
  output sys_data_t                              sys_rdata_o,
  output logic                                   sys_ack_o,
  output logic                                   sys_err_o
);

  localparam int REG_HK   = 0;
  localparam int REG_CTRL = 1;
  localparam int REG_GEN  = 2;

  // Region bus
  logic [`RP_N_REG-1:0][`RP_REG_AW-1:0] reg_addr;
  sys_data_t [`RP_N_REG-1:0]            reg_wdata;
  logic [`RP_N_REG-1:0]                 reg_wen;
  logic [`RP_N_REG-1:0]                 reg_ren;
  sys_data_t [`RP_N_REG-1:0]            reg_rdata;
  logic [`RP_N_REG-1:0]                 reg_ack;

  // Sample path
  sample_arr_t adc_smp;
  sample_arr_t ctrl_smp;
  sample_arr_t gen_smp;
  sample_arr_t dac_smp;       // Also the loopback source
  logic        digital_loop;

  //////////////////////////////////////////////////
  // System bus
  //////////////////////////////////////////////////

  sys_bus_decoder #(
    .REG_MAP (`RP_N_REG'(1 << REG_HK | 1 << REG_CTRL | 1 << REG_GEN))
  ) i_bus (
    .adc_clk, .reset_i,
    .sys_addr_i, .sys_wdata_i, .sys_wen_i, .sys_ren_i,
    .sys_rdata_o, .sys_ack_o, .sys_err_o,
    .reg_addr_o  (reg_addr),
    .reg_wdata_o (reg_wdata),
    .reg_wen_o   (reg_wen),
    .reg_ren_o   (reg_ren),
    .reg_rdata_i (reg_rdata),
    .reg_ack_i   (reg_ack)
  );

  // Regions 3..7 stay silent
  for (genvar r = REG_GEN + 1; r < `RP_N_REG; r++) begin : g_empty
    assign reg_rdata[r] = '0;
    assign reg_ack[r]   = 1'b0;
  end

  housekeeping i_hk (
    .adc_clk, .reset_i,
    .sys_addr_i (reg_addr[REG_HK]), .sys_wdata_i (reg_wdata[REG_HK]),
    .sys_wen_i  (reg_wen[REG_HK]),  .sys_ren_i   (reg_ren[REG_HK]),
    .sys_rdata_o (reg_rdata[REG_HK]), .sys_ack_o (reg_ack[REG_HK]),
    .digital_loop_o (digital_loop),
    .led_o
  );

  //////////////////////////////////////////////////
  // Signal path
  //////////////////////////////////////////////////

  adc_frontend i_adc (
    .adc_clk, .reset_i, .adc_dat_i,
    .loop_smp_i (dac_smp), .digital_loop_i (digital_loop), .smp_o (adc_smp)
  );

  prop_ctrl i_ctrl (
    .adc_clk, .reset_i,
    .sys_addr_i (reg_addr[REG_CTRL]), .sys_wdata_i (reg_wdata[REG_CTRL]),
    .sys_wen_i  (reg_wen[REG_CTRL]),  .sys_ren_i   (reg_ren[REG_CTRL]),
    .sys_rdata_o (reg_rdata[REG_CTRL]), .sys_ack_o (reg_ack[REG_CTRL]),
    .smp_i (adc_smp), .ctrl_o (ctrl_smp)
  );

  dc_gen i_gen (
    .adc_clk, .reset_i,
    .sys_addr_i (reg_addr[REG_GEN]), .sys_wdata_i (reg_wdata[REG_GEN]),
    .sys_wen_i  (reg_wen[REG_GEN]),  .sys_ren_i   (reg_ren[REG_GEN]),
    .sys_rdata_o (reg_rdata[REG_GEN]), .sys_ack_o (reg_ack[REG_GEN]),
    .level_o (gen_smp)
  );

  dac_backend i_dac (
    .adc_clk, .reset_i,
    .gen_i (gen_smp), .ctrl_i (ctrl_smp), .smp_o (dac_smp), .dac_dat_o
  );

endmodule

//--- tests/tb_top.sv
`include "rp_defs.svh"

module tb_top import rp_pkg::*; ();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int     SW         = `RP_SMP_W;
  localparam int     NCH        = `RP_N_CH;
  localparam int     PERIOD     = 100;  // adc_clk, ns
  localparam int     N_SMP      = 100;  // Cycles per random sample run
  localparam int     N_ACCESS   = 80;   // Upper bound of bus accesses
  // Reset, 3 cycles per access, 7 sample runs, then margin
  localparam int     RUN_CYCLES = 5 + 3 * N_ACCESS + 7 * N_SMP + 100;
  localparam longint SMP_MAX    = (longint'(1) << (SW - 1)) - 1;
  localparam longint SMP_MIN    = -SMP_MAX - 1;

  logic                              adc_clk = 1'b0;
  logic                              reset_i;
  logic [NCH-1:0][`RP_ADC_RAW_W-1:0] adc_dat_i;
  logic [NCH-1:0][SW-1:0]            dac_dat_o;
  logic [7:0]                        led_o;
  sys_addr_t                         sys_addr_i;
  sys_data_t                         sys_wdata_i;
  logic                              sys_wen_i;
  logic                              sys_ren_i;
  sys_data_t                         sys_rdata_o;
  logic                              sys_ack_o;
  logic                              sys_err_o;
  int                                seed = 55;

  // Reference model state, same register stages as the board
  sample_t                m_adc   [NCH];
  int                     m_err   [NCH];
  sample_t                m_ctrl  [NCH];
  sample_t                m_dac   [NCH];
  sample_t                m_set   [NCH];
  sample_t                m_gain  [NCH];
  logic [3:0]             m_shift [NCH];
  sample_t                m_gen   [NCH];
  logic                   m_loop;
  logic [7:0]             m_led;
  logic [NCH-1:0][SW-1:0] exp_pins;

  logic [2:0]            bus_region;
  logic [`RP_REG_AW-1:0] bus_offset;
  logic                  bus_strobe;
  logic                  bus_unmapped;

  assign bus_region   = sys_addr_i[`RP_REG_AW +: 3];
  assign bus_offset   = sys_addr_i[`RP_REG_AW-1:0];
  assign bus_strobe   = sys_wen_i | sys_ren_i;
  assign bus_unmapped = bus_region > 3'd2;  // Only regions 0..2 populated

  always #(PERIOD / 2) adc_clk = ~adc_clk;

  rp_top dut_i (.*);

  //////////////////////////////////////////////////
  // Conversion rules
  //////////////////////////////////////////////////

  // Bits 15..2, MSB kept, rest inverted
  function automatic sample_t raw_to_sample(input logic [`RP_ADC_RAW_W-1:0] raw);
    logic [SW-1:0] top;
    top = raw[`RP_ADC_RAW_W-1 -: SW];
    return sample_t'({top[SW-1], ~top[SW-2:0]});
  endfunction

  function automatic logic [SW-1:0] sample_to_pins(input sample_t s);
    return {s[SW-1], ~s[SW-2:0]};
  endfunction

  function automatic sample_t clamp_sample(input longint v);
    if (v > SMP_MAX)
      return sample_t'(SMP_MAX);
    if (v < SMP_MIN)
      return sample_t'(SMP_MIN);
    return sample_t'(v);
  endfunction

  function automatic sys_addr_t region_addr(input int region, input int offset);
    return sys_addr_t'((region << `RP_REG_AW) | offset);
  endfunction

  //////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////

  always @(posedge adc_clk) begin
    if (reset_i) begin
      for (int c = 0; c < NCH; c++) begin
        m_adc[c]   <= '0;
        m_err[c]   <= 0;
        m_ctrl[c]  <= '0;
        m_dac[c]   <= '0;   // Pins at 0x1FFF
        m_set[c]   <= '0;
        m_gain[c]  <= '0;
        m_shift[c] <= '0;
        m_gen[c]   <= '0;
      end
      m_loop <= 1'b0;
      m_led  <= '0;
    end else begin
      for (int c = 0; c < NCH; c++) begin
        m_adc[c]  <= raw_to_sample(adc_dat_i[c]);                         // Input register
        m_err[c]  <= int'(m_set[c]) - int'(m_loop ? m_dac[c] : m_adc[c]);
        m_ctrl[c] <= clamp_sample((longint'(m_err[c]) * longint'(m_gain[c])) >>> m_shift[c]);
        m_dac[c]  <= clamp_sample(longint'(m_gen[c]) + longint'(m_ctrl[c]));
      end
      // Register writes land on the strobe edge
      if (sys_wen_i) begin
        case (bus_region)
          3'd0: begin
            if (bus_offset == 'h4) m_loop <= sys_wdata_i[0];
            if (bus_offset == 'h8) m_led <= sys_wdata_i[7:0];
          end
          3'd1: begin
            for (int c = 0; c < NCH; c++) begin
              if (bus_offset == `RP_REG_AW'(16 * c))     m_set[c]   <= sys_wdata_i[SW-1:0];
              if (bus_offset == `RP_REG_AW'(16 * c + 4)) m_gain[c]  <= sys_wdata_i[SW-1:0];
              if (bus_offset == `RP_REG_AW'(16 * c + 8)) m_shift[c] <= sys_wdata_i[3:0];
            end
          end
          3'd2: begin
            for (int c = 0; c < NCH; c++) begin
              if (bus_offset == `RP_REG_AW'(4 * c)) m_gen[c] <= sys_wdata_i[SW-1:0];
            end
          end
          default: ;  // Unmapped, nothing stored
        endcase
      end
    end
  end

  always_comb begin
    for (int c = 0; c < NCH; c++) begin
      exp_pins[c] = sample_to_pins(m_dac[c]);
    end
  end

  //////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("FAIL: see errors above");
    $fatal(1);
  endtask

  task automatic report_error(input string msg);
    abort_run($sformatf("Error at %0d ns: %s", $time, msg));
  endtask

  a_ack: assert property (@(posedge adc_clk) disable iff (reset_i)
    bus_strobe |=> sys_ack_o && (sys_err_o == $past(bus_unmapped)))
    else report_error("strobe not followed by the right acknowledge one cycle later");

  a_idle: assert property (@(posedge adc_clk) disable iff (reset_i)
    !bus_strobe |=> !sys_ack_o && !sys_err_o)
    else report_error("acknowledge or error without a strobe");

  a_dac: assert property (@(posedge adc_clk) disable iff (reset_i) dac_dat_o == exp_pins)
    else report_error($sformatf("dac_dat_o is %h, expected %h",
                                $sampled(dac_dat_o), $sampled(exp_pins)));

  a_led: assert property (@(posedge adc_clk) disable iff (reset_i) led_o == m_led)
    else report_error($sformatf("led_o is %h, expected %h", $sampled(led_o), $sampled(m_led)));

  //////////////////////////////////////////////////
  // Stimulus tasks
  //////////////////////////////////////////////////

  // Entered and left 10 ns after a rising edge
  task automatic bus_xfer(input logic wr, input sys_addr_t addr, input sys_data_t wdata,
                          output sys_data_t rdata, output logic err);
    int waited;
    waited      = 0;
    sys_addr_i  = addr;
    sys_wdata_i = wdata;
    sys_wen_i   = wr;
    sys_ren_i   = !wr;
    @(posedge adc_clk);
    #10;
    sys_wen_i = 1'b0;   // Single-cycle strobe
    sys_ren_i = 1'b0;
    while (!sys_ack_o) begin
      if (waited == 4)
        abort_run("A bus access got no acknowledge within 4 cycles");
      @(posedge adc_clk);
      #10;
      waited++;
    end
    rdata = sys_rdata_o;
    err   = sys_err_o;
    @(posedge adc_clk);  // Idle cycle before next strobe
    #10;
  endtask

  task automatic write_check(input sys_addr_t addr, input sys_data_t data, input logic exp_err);
    sys_data_t rd;
    logic      err;
    bus_xfer(1'b1, addr, data, rd, err);
    assert (err == exp_err)
      else report_error($sformatf("write to %h returned error flag %b", addr, err));
  endtask

  task automatic read_check(input sys_addr_t addr, input sys_data_t exp, input logic exp_err);
    sys_data_t rd;
    logic      err;
    bus_xfer(1'b0, addr, '0, rd, err);
    assert (rd == exp && err == exp_err)
      else report_error($sformatf("read %h gave %h err %b, expected %h err %b",
                                  addr, rd, err, exp, exp_err));
  endtask

  task automatic wait_cycles(input int n);
    repeat (n) @(posedge adc_clk);
    #10;
  endtask

  // New random pin word every cycle
  task automatic drive_random_adc(input int n);
    repeat (n) begin
      for (int c = 0; c < NCH; c++)
        adc_dat_i[c] = `RP_ADC_RAW_W'($random(seed));
      @(posedge adc_clk);
      #10;
    end
  endtask

  task automatic zero_gains();
    for (int c = 0; c < NCH; c++)
      write_check(region_addr(1, 16 * c + 4), '0, 1'b0);
  endtask

  task automatic randomize_config();
    for (int c = 0; c < NCH; c++) begin
      write_check(region_addr(1, 16 * c), $random(seed), 1'b0);      // Setpoint
      write_check(region_addr(1, 16 * c + 4), $random(seed), 1'b0);  // Gain
      write_check(region_addr(1, 16 * c + 8), $random(seed), 1'b0);  // Shift
      write_check(region_addr(2, 4 * c), $random(seed), 1'b0);       // DC level
    end
  endtask

  //////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////

  initial begin : stimulus
    sample_t                lvl [NCH];
    longint                 ext;
    logic [NCH-1:0][SW-1:0] held;
    reset_i     = 1'b1;
    adc_dat_i   = '0;
    sys_addr_i  = '0;
    sys_wdata_i = '0;
    sys_wen_i   = 1'b0;
    sys_ren_i   = 1'b0;
    repeat (5) @(posedge adc_clk);
    #10 reset_i = 1'b0;
    wait_cycles(1);

    assert (!sys_ack_o && !sys_err_o && led_o == '0)
      else report_error("bus or LEDs not idle after reset");
    assert (dac_dat_o == {NCH{14'h1FFF}})
      else report_error($sformatf("dac_dat_o is %h after reset", dac_dat_o));

    // Register map, readback and error regions
    read_check(region_addr(0, 'h0), `RP_HK_ID, 1'b0);
    write_check(region_addr(0, 'h0), 32'hDEAD_BEEF, 1'b0);  // ID is read-only
    read_check(region_addr(0, 'h0), `RP_HK_ID, 1'b0);
    write_check(region_addr(0, 'h8), 32'h0000_01A5, 1'b0);
    read_check(region_addr(0, 'h8), 32'h0000_00A5, 1'b0);
    write_check(region_addr(0, 'h4), 32'h1, 1'b0);
    read_check(region_addr(0, 'h4), 32'h1, 1'b0);
    write_check(region_addr(0, 'h4), 32'h0, 1'b0);
    read_check(region_addr(0, 'h4), 32'h0, 1'b0);
    read_check(region_addr(0, 'h40), '0, 1'b0);              // Hole
    write_check(region_addr(1, 'h10), 32'h0000_3F9C, 1'b0);  // Setpoint ch1 -100
    read_check(region_addr(1, 'h10), 32'hFFFF_FF9C, 1'b0);
    write_check(region_addr(1, 'h4), 32'h0000_1FFF, 1'b0);
    read_check(region_addr(1, 'h4), 32'h0000_1FFF, 1'b0);
    write_check(region_addr(1, 'h18), 32'h0000_00F7, 1'b0);  // Shift keeps 4 bits
    read_check(region_addr(1, 'h18), 32'h0000_0007, 1'b0);
    write_check(region_addr(2, 'h0), 32'h0000_2000, 1'b0);
    read_check(region_addr(2, 'h0), 32'hFFFF_E000, 1'b0);
    read_check(region_addr(2, 'h8), '0, 1'b0);
    write_check(region_addr(5, 'h0), 32'h1, 1'b1);
    read_check(region_addr(5, 'h4), '0, 1'b1);
    read_check(region_addr(7, 'h0), '0, 1'b1);

    // DC levels straight to the pins
    zero_gains();
    for (int c = 0; c < NCH; c++) begin
      lvl[c] = sample_t'($random(seed));
      write_check(region_addr(2, 4 * c), sys_data_t'(lvl[c]), 1'b0);
    end
    wait_cycles(2);
    for (int c = 0; c < NCH; c++)
      assert (dac_dat_o[c] == sample_to_pins(lvl[c]))
        else report_error($sformatf("channel %0d does not show its DC level", c));
    drive_random_adc(N_SMP);

    // Controller with random settings
    repeat (3) begin
      randomize_config();
      drive_random_adc(N_SMP);
    end

    // Both saturation extremes, ch0 high, ch1 low
    for (int c = 0; c < NCH; c++) begin
      ext = (c == 0) ? SMP_MAX : SMP_MIN;
      adc_dat_i[c] = {sample_to_pins(sample_t'((c == 0) ? SMP_MIN : SMP_MAX)), 2'b00};
      write_check(region_addr(2, 4 * c), sys_data_t'(ext), 1'b0);
      write_check(region_addr(1, 16 * c), sys_data_t'(ext), 1'b0);
      write_check(region_addr(1, 16 * c + 4), sys_data_t'(SMP_MAX), 1'b0);
      write_check(region_addr(1, 16 * c + 8), '0, 1'b0);
    end
    wait_cycles(5);
    assert (dac_dat_o[0] == 14'h0000 && dac_dat_o[1] == 14'h3FFF)
      else report_error($sformatf("saturated dac_dat_o is %h", dac_dat_o));

    // Loopback, pins cut off
    // Loop parked at zero under full gain so any pin leakage would show
    zero_gains();
    for (int c = 0; c < NCH; c++) begin
      write_check(region_addr(2, 4 * c), '0, 1'b0);   // DC level
      write_check(region_addr(1, 16 * c), '0, 1'b0);  // Setpoint
    end
    write_check(region_addr(0, 'h4), 32'h1, 1'b0);
    for (int c = 0; c < NCH; c++)
      write_check(region_addr(1, 16 * c + 4), sys_data_t'(SMP_MAX), 1'b0);
    wait_cycles(4);
    held = dac_dat_o;
    repeat (N_SMP) begin
      drive_random_adc(1);
      assert (dac_dat_o == held)
        else report_error("dac_dat_o moved with the ADC pins in loopback");
    end
    randomize_config();       // Loop closed through the DAC register
    drive_random_adc(N_SMP);
    write_check(region_addr(0, 'h4), 32'h0, 1'b0);
    drive_random_adc(N_SMP);  // Pins back in the path

    $display("PASS: all tests");
    $finish;
  end

  // Watchdog
  initial begin
    #(RUN_CYCLES * PERIOD);
    abort_run($sformatf("Timeout: the tests did not finish within %0d clock cycles",
                        RUN_CYCLES));
  end

endmodule

//--- verilog.f
+incdir+common
common/rp_pkg.sv
rtl/sys_bus_decoder.sv
rtl/housekeeping.sv
rtl/dc_gen.sv
rtl/prop_ctrl.sv
analog/adc_frontend.sv
analog/dac_backend.sv
rtl/rp_top.sv
tests/tb_top.sv
